// File: displayListEngine.f
+incdir+rtl
rtl/anticPkg.sv
rtl/dmaControl.sv
rtl/fetchPort.sv
rtl/instructionSequencer.sv
rtl/mapLineShifter.sv
rtl/displayListEngine.sv
testbench/displayListChecker.sv
testbench/displayListTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the display-list engine testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module displayListTb \
  -f displayListEngine.f -o displayListSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

simOut=$(./obj_dir/displayListSim)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
  echo "Simulator exited with status $simStatus"
  exit 1
fi

if echo "$simOut" | grep -qx "Simulation passed"; then
  exit 0
fi
exit 1

// File: testbench/displayListTb.sv
// Testbench for the display-list engine with a memory model of random latency
// Runs a table of display lists and checks codes and interrupts through the checker
`include "anticSettings.svh"

module displayListTb;

  localparam int NumCases = 6;
  localparam int WaitLimit = 30000;

  logic Fphi0;
  logic rst;
  anticPkg::regWrite regIn;
  logic vblank;
  anticPkg::fetchReq fetchReq;
  anticPkg::fetchRsp fetchRsp;
  anticPkg::anCode an;
  anticPkg::nmiEvent nmi;

  logic [7:0] mem [65536];
  logic [7:0] dlTable [NumCases][8];
  logic [7:0] targetList [4];
  logic [7:0] dmactlTable [NumCases];
  int blankTable [NumCases];
  int bytesTable [NumCases];
  logic [15:0] scanTable [NumCases];
  logic doubleTable [NumCases];
  int dliTable [NumCases];
  int vbiTable [NumCases];
  logic vblankTestTable [NumCases];
  anticPkg::anCode pixelMap [4];
  int unsigned lcgState;
  int unsigned cycle;
  logic [16:0] pendReq[$];
  int unsigned pendDue[$];

  displayListEngine uut (
    .Fphi0(Fphi0),
    .rst(rst),
    .regIn(regIn),
    .vblank(vblank),
    .fetchReq(fetchReq),
    .fetchRsp(fetchRsp),
    .an(an),
    .nmi(nmi)
  );

  displayListChecker chk (
    .Fphi0(Fphi0),
    .rst(rst),
    .an(an),
    .nmi(nmi),
    .req(fetchReq),
    .rsp(fetchRsp)
  );

  always #20 Fphi0 = ~Fphi0;

  function automatic int unsigned nextRand();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState >> 16;
  endfunction

  // Memory answers in request order after 1 to 4 cycles and echoes the kind
  always @(posedge Fphi0) begin
    cycle <= cycle + 1;
    if (rst) begin
      pendReq.delete();
      pendDue.delete();
      fetchRsp <= '0;
    end else begin
      fetchRsp <= '0;
      if (pendReq.size() != 0 && pendDue[0] <= cycle) begin
        fetchRsp.valid <= 1'b1;
        fetchRsp.kind <= anticPkg::fetchKind'(pendReq[0][16]);
        fetchRsp.data <= mem[pendReq[0][15:0]];
        void'(pendReq.pop_front());
        void'(pendDue.pop_front());
      end
      if (fetchReq.valid) begin
        pendReq.push_back({fetchReq.kind, fetchReq.addr});
        pendDue.push_back(cycle + 1 + nextRand() % 4);
      end
    end
  end

  task automatic writeReg(input anticPkg::regSel sel, input logic [7:0] data);
    @(posedge Fphi0);
    regIn.valid <= 1'b1;
    regIn.sel <= sel;
    regIn.data <= data;
    @(posedge Fphi0);
    regIn <= '0;
  endtask

  task automatic loadExpected(input int c);
    logic [7:0] b;
    logic [1:0] pix;
    repeat (blankTable[c] * `ANTIC_LINE_PIXELS) chk.pushCode(anticPkg::bgColor);
    for (int i = 0; i < bytesTable[c]; i++) begin
      b = mem[scanTable[c] + 16'(i)];
      for (int p = 0; p < 4; p++) begin
        pix = b[7:6];
        b = b << 2;
        chk.pushCode(pixelMap[pix]);
        if (doubleTable[c]) begin
          chk.pushCode(pixelMap[pix]);
        end
      end
    end
  endtask

  task automatic waitVbiCount(input int target);
    int n;
    n = 0;
    while (chk.vbiCount < target && n < WaitLimit) begin
      @(negedge Fphi0);
      n++;
    end
    if (chk.vbiCount < target) begin
      chk.noteTimeout("a vertical-blank interrupt");
    end
  endtask

  task automatic waitCodesDone();
    int n;
    n = 0;
    while (chk.expQ.size() != 0 && n < WaitLimit) begin
      @(negedge Fphi0);
      n++;
    end
    if (chk.expQ.size() != 0) begin
      chk.noteTimeout("the expected colour codes");
    end
  endtask

  // Releases vblank and checks that the jump target is fetched next
  task automatic checkVblankJump();
    int n;
    for (int i = 0; i < 20; i++) begin
      @(negedge Fphi0);
      if (fetchReq.valid) begin
        chk.reportProblem("request sent while waiting for vertical blank");
      end
    end
    @(posedge Fphi0);
    vblank <= 1'b1;
    n = 0;
    @(negedge Fphi0);
    while (!fetchReq.valid && n < 100) begin
      @(negedge Fphi0);
      n++;
    end
    if (!fetchReq.valid) begin
      chk.noteTimeout("the fetch after vertical blank");
    end else if (fetchReq.addr != 16'h2010) begin
      chk.reportValue("fetchReq.addr", 32'h2010, int'(fetchReq.addr));
    end
    @(posedge Fphi0);
    vblank <= 1'b0;
  endtask

  initial begin
    logic [15:0] ad;
    Fphi0 = 1'b0;
    rst = 1'b1;
    regIn = '0;
    vblank = 1'b0;
    fetchRsp = '0;
    cycle = 0;
    lcgState = 28023;
    for (int a = 0; a < 65536; a++) begin
      ad = 16'(a);
      mem[a] = (ad[7:0] * 8'd29) ^ ad[15:8] ^ 8'h5A;
    end
    // Colour code for each two-bit pixel value
    pixelMap = '{anticPkg::bgColor, anticPkg::playfield0, anticPkg::playfield1,
                 anticPkg::playfield2};
    // Every list ends in a jump-and-wait back to its start at 0x2000
    dlTable = '{'{8'h20, 8'h41, 8'h00, 8'h20, 8'h00, 8'h00, 8'h00, 8'h00},
                '{8'h4E, 8'h24, 8'h30, 8'h41, 8'h00, 8'h20, 8'h00, 8'h00},
                '{8'h4D, 8'h00, 8'h31, 8'h41, 8'h00, 8'h20, 8'h00, 8'h00},
                '{8'h4D, 8'h00, 8'h31, 8'h41, 8'h00, 8'h20, 8'h00, 8'h00},
                '{8'h41, 8'h10, 8'h20, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00},
                '{8'hCE, 8'h00, 8'h30, 8'h41, 8'h00, 8'h20, 8'h00, 8'h00}};
    targetList = '{8'h80, 8'h41, 8'h00, 8'h20};
    dmactlTable = '{8'h22, 8'h22, 8'h21, 8'h20, 8'h22, 8'h22};
    blankTable = '{3, 0, 0, 0, 1, 0};
    bytesTable = '{0, `ANTIC_BYTES_STANDARD, `ANTIC_BYTES_NARROW, 0, 0, `ANTIC_BYTES_STANDARD};
    scanTable = '{16'h0000, 16'h3024, 16'h3100, 16'h3100, 16'h0000, 16'h3000};
    doubleTable = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0};
    dliTable = '{0, 0, 0, 0, 1, 1};
    vbiTable = '{1, 1, 1, 1, 2, 1};
    vblankTestTable = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};

    for (int c = 0; c < NumCases; c++) begin
      @(posedge Fphi0);
      rst <= 1'b1;
      repeat (5) @(posedge Fphi0);
      for (int i = 0; i < 8; i++) begin
        mem[16'h2000 + 16'(i)] = dlTable[c][i];
      end
      for (int i = 0; i < 4; i++) begin
        mem[16'h2010 + 16'(i)] = targetList[i];
      end
      loadExpected(c);
      rst <= 1'b0;
      writeReg(anticPkg::dlistLoReg, 8'h00);
      writeReg(anticPkg::dlistHiReg, 8'h20);
      writeReg(anticPkg::dmactlReg, dmactlTable[c]);
      if (vblankTestTable[c]) begin
        waitVbiCount(1);
        checkVblankJump();
      end
      waitVbiCount(vbiTable[c]);
      waitCodesDone();
      repeat (10) @(negedge Fphi0);
      chk.finishCase(c, dliTable[c], vbiTable[c]);
    end

    $display("Checks done with %0d errors and %0d timeouts", chk.errors, chk.timeouts);
    if (chk.errors == 0 && chk.timeouts == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: testbench/displayListChecker.sv
// Watches the display-list engine ports and compares colour codes and interrupts
// The testbench loads expected codes per case and asks for a verdict at the end of each case
`include "anticSettings.svh"

module displayListChecker (
  input  logic Fphi0,
  input  logic rst,
  input  anticPkg::anCode an,
  input  anticPkg::nmiEvent nmi,
  input  anticPkg::fetchReq req,
  input  anticPkg::fetchRsp rsp
);

  anticPkg::anCode expQ[$];
  anticPkg::anCode prevCode;
  int errors;
  int timeouts;
  int dliCount;
  int vbiCount;
  int outstanding;

  initial begin
    errors = 0;
    timeouts = 0;
  end

  task automatic pushCode(input anticPkg::anCode code);
    expQ.push_back(code);
  endtask

  task automatic reportValue(input string name, input int expected, input int actual);
    errors++;
    $display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, expected, actual);
  endtask

  task automatic reportProblem(input string what);
    errors++;
    $display("Error at %0t: %s", $time, what);
  endtask

  task automatic noteTimeout(input string what);
    timeouts++;
    $display("Timeout at %0t while waiting for %s", $time, what);
  endtask

  // Closes one case and flags leftover expected codes or wrong interrupt counts
  task automatic finishCase(input int caseNum, input int expDli, input int expVbi);
    if (expQ.size() != 0) begin
      reportProblem($sformatf("case %0d: %0d colour codes never arrived", caseNum, expQ.size()));
    end
    expQ.delete();
    if (dliCount != expDli) begin
      reportValue("nmi.dli count", expDli, dliCount);
    end
    if (vbiCount != expVbi) begin
      reportValue("nmi.vbi count", expVbi, vbiCount);
    end
  endtask

  always @(posedge Fphi0) begin
    if (rst) begin
      dliCount <= 0;
      vbiCount <= 0;
      outstanding <= 0;
      prevCode <= anticPkg::noTransmission;
    end else begin
      prevCode <= an;
      outstanding <= outstanding + int'(req.valid) - int'(rsp.valid);
      if (outstanding > `ANTIC_FETCH_CREDITS) begin
        reportValue("outstanding reads", `ANTIC_FETCH_CREDITS, outstanding);
      end
      if (an != anticPkg::noTransmission) begin
        if (expQ.size() == 0) begin
          reportProblem($sformatf("unexpected colour code %0d", an));
        end else begin
          if (an != expQ[0]) begin
            reportValue("an", int'(expQ[0]), int'(an));
          end
          void'(expQ.pop_front());
        end
      end
      if (nmi.dli) begin
        dliCount <= dliCount + 1;
        // The interrupt belongs right after the line's last colour code
        if (prevCode == anticPkg::noTransmission) begin
          reportProblem("display-list interrupt did not follow a colour code");
        end
      end
      if (nmi.vbi) begin
        vbiCount <= vbiCount + 1;
      end
    end
  end

endmodule

// File: rtl/displayListEngine.sv
// Display-list engine top level
// Registers, fetch port, sequencer and shifter wired together
`include "anticSettings.svh"

module displayListEngine (
  input  logic Fphi0,
  input  logic rst,
  input  anticPkg::regWrite regIn,
  input  logic vblank,
  output anticPkg::fetchReq fetchReq,
  input  anticPkg::fetchRsp fetchRsp,
  output anticPkg::anCode an,
  output anticPkg::nmiEvent nmi
);

  anticPkg::seqCmd cmd;
  anticPkg::fetchRsp instrRsp;
  anticPkg::fetchRsp screenRsp;
  logic dlistEnable;
  logic [6:0] playfieldBytes;
  logic [`ANTIC_ADDR_W-1:0] startPtr;
  logic startLoad;
  logic screenWant;
  logic screenTaken;
  logic lineDone;
  logic [10:0] blankCount;

  dmaControl regs (
    .Fphi0(Fphi0),
    .rst(rst),
    .regIn(regIn),
    .dlistEnable(dlistEnable),
    .playfieldBytes(playfieldBytes),
    .startPtr(startPtr),
    .startLoad(startLoad)
  );

  fetchPort port (
    .Fphi0(Fphi0),
    .rst(rst),
    .cmd(cmd),
    .screenWant(screenWant),
    .startPtr(startPtr),
    .startLoad(startLoad),
    .req(fetchReq),
    .rsp(fetchRsp),
    .instrRsp(instrRsp),
    .screenRsp(screenRsp),
    .screenTaken(screenTaken)
  );

  instructionSequencer seq (
    .Fphi0(Fphi0),
    .rst(rst),
    .dlistEnable(dlistEnable),
    .vblank(vblank),
    .instrRsp(instrRsp),
    .lineDone(lineDone),
    .cmd(cmd),
    .blankCount(blankCount),
    .nmi(nmi)
  );

  mapLineShifter shifter (
    .Fphi0(Fphi0),
    .rst(rst),
    .cmd(cmd),
    .playfieldBytes(playfieldBytes),
    .blankCount(blankCount),
    .screenRsp(screenRsp),
    .screenWant(screenWant),
    .screenTaken(screenTaken),
    .lineDone(lineDone),
    .an(an)
  );

endmodule

// File: rtl/mapLineShifter.sv
// Turns screen bytes into four-colour pixels and emits blank-line background codes
// One colour code leaves per cycle while a byte or blank run is held
module mapLineShifter (
  input  logic Fphi0,
  input  logic rst,
  input  anticPkg::seqCmd cmd,
  input  logic [6:0] playfieldBytes,
  input  logic [10:0] blankCount,
  input  anticPkg::fetchRsp screenRsp,
  output logic screenWant,
  input  logic screenTaken,
  output logic lineDone,
  output anticPkg::anCode an
);

  // Bytes either in flight or waiting in the buffer
  localparam int Slots = 2;

  logic mapActive;
  logic blankActive;
  logic haveByte;
  logic doubling;
  logic phase;
  logic [1:0] pixCnt;
  logic [7:0] shiftReg;
  logic [6:0] reqLeft;
  logic [6:0] useLeft;
  logic [10:0] blankLeft;
  logic [1:0] slotsUsed;
  logic [1:0] fifoCount;
  logic wrPtr;
  logic rdPtr;
  logic [7:0] fifoMem [Slots];
  logic lastPix;
  logic pop;

  function automatic anticPkg::anCode pixelCode(input logic [1:0] pix);
    case (pix)
      2'd0: return anticPkg::bgColor;
      2'd1: return anticPkg::playfield0;
      2'd2: return anticPkg::playfield1;
      default: return anticPkg::playfield2;
    endcase
  endfunction

  assign lastPix = haveByte && pixCnt == 2'd3 && (!doubling || phase);
  // The next byte follows the last pixel with no gap when it is already here
  assign pop = fifoCount != 2'd0 && (!haveByte || lastPix);
  assign screenWant = mapActive && reqLeft != 7'd0 && slotsUsed < 2'(Slots);

  always_ff @(posedge Fphi0 or posedge rst) begin
    if (rst) begin
      mapActive <= 1'b0;
      blankActive <= 1'b0;
      haveByte <= 1'b0;
      doubling <= 1'b0;
      phase <= 1'b0;
      pixCnt <= 2'd0;
      reqLeft <= 7'd0;
      useLeft <= 7'd0;
      blankLeft <= 11'd0;
      slotsUsed <= 2'd0;
      fifoCount <= 2'd0;
      wrPtr <= 1'b0;
      rdPtr <= 1'b0;
      lineDone <= 1'b0;
      an <= anticPkg::noTransmission;
    end else begin
      an <= anticPkg::noTransmission;
      lineDone <= 1'b0;
      wrPtr <= wrPtr ^ screenRsp.valid;
      rdPtr <= rdPtr ^ pop;
      fifoCount <= fifoCount + 2'(screenRsp.valid) - 2'(pop);
      slotsUsed <= slotsUsed + 2'(screenTaken) - 2'(pop);
      if (screenTaken) begin
        reqLeft <= reqLeft - 7'd1;
      end
      if (haveByte) begin
        an <= pixelCode(shiftReg[7:6]);
        if (doubling && !phase) begin
          phase <= 1'b1;
        end else begin
          phase <= 1'b0;
          pixCnt <= pixCnt + 2'd1;
        end
        if (lastPix) begin
          haveByte <= 1'b0;
        end
      end
      if (pop) begin
        haveByte <= 1'b1;
        pixCnt <= 2'd0;
        phase <= 1'b0;
        useLeft <= useLeft - 7'd1;
      end
      if (mapActive && useLeft == 7'd0 && (!haveByte || lastPix)) begin
        mapActive <= 1'b0;
        lineDone <= 1'b1;
      end
      if (blankActive) begin
        an <= anticPkg::bgColor;
        blankLeft <= blankLeft - 11'd1;
        if (blankLeft == 11'd1) begin
          blankActive <= 1'b0;
          lineDone <= 1'b1;
        end
      end
      if (cmd.lineStart) begin
        if (blankCount != 11'd0) begin
          blankActive <= 1'b1;
          blankLeft <= blankCount;
        end else begin
          mapActive <= 1'b1;
          reqLeft <= playfieldBytes;
          useLeft <= playfieldBytes;
          doubling <= cmd.lineDouble;
        end
      end
    end
  end

  always_ff @(posedge Fphi0) begin
    if (screenRsp.valid) begin
      fifoMem[wrPtr] <= screenRsp.data;
    end
    if (pop) begin
      shiftReg <= fifoMem[rdPtr];
    end else if (haveByte && !(doubling && !phase)) begin
      shiftReg <= shiftReg << 2;
    end
  end

endmodule

// File: rtl/instructionSequencer.sv
// Fetches and decodes display-list instructions and steers the fetch port and shifter
// Raises the display-list and vertical-blank interrupts as one-cycle pulses
`include "anticSettings.svh"

module instructionSequencer (
  input  logic Fphi0,
  input  logic rst,
  input  logic dlistEnable,
  input  logic vblank,
  input  anticPkg::fetchRsp instrRsp,
  input  logic lineDone,
  output anticPkg::seqCmd cmd,
  output logic [10:0] blankCount,
  output anticPkg::nmiEvent nmi
);

  typedef enum logic [2:0] {
    idle,
    fetchInstr,
    fetchLo,
    fetchHi,
    blankRun,
    lineRun,
    waitVblank
  } seqState;

  seqState state;
  logic [7:0] instr;
  logic [2:0] linesLeft;
  anticPkg::instrOp newOp;
  anticPkg::instrOp heldOp;
  logic isJump;

  assign newOp = anticPkg::instrOp'(instrRsp.data[3:0]);
  assign heldOp = anticPkg::instrOp'(instr[3:0]);
  assign isJump = heldOp == anticPkg::jumpOp;

  // Every line started while in blankRun is a full blank scan line
  assign blankCount = (state == blankRun) ? 11'(`ANTIC_LINE_PIXELS) : 11'd0;

  always_ff @(posedge Fphi0 or posedge rst) begin
    if (rst) begin
      state <= idle;
      instr <= 8'd0;
      linesLeft <= 3'd0;
      cmd <= '0;
      nmi <= '0;
    end else begin
      cmd <= '0;
      nmi <= '0;
      case (state)
        idle: begin
          if (dlistEnable) begin
            cmd.instrReq <= 1'b1;
            state <= fetchInstr;
          end
        end
        fetchInstr: begin
          if (instrRsp.valid) begin
            instr <= instrRsp.data;
            case (newOp)
              anticPkg::blankOp: begin
                linesLeft <= instrRsp.data[6:4];
                cmd.lineStart <= 1'b1;
                state <= blankRun;
              end
              anticPkg::jumpOp: begin
                cmd.instrReq <= 1'b1;
                state <= fetchLo;
              end
              anticPkg::map4DoubleOp, anticPkg::map4Op: begin
                // Bit 6 asks for a new scan address before the line
                if (instrRsp.data[6]) begin
                  cmd.instrReq <= 1'b1;
                  state <= fetchLo;
                end else begin
                  cmd.lineStart <= 1'b1;
                  cmd.lineDouble <= newOp == anticPkg::map4DoubleOp;
                  state <= lineRun;
                end
              end
              default: begin
                cmd.instrReq <= 1'b1;
              end
            endcase
          end
        end
        fetchLo: begin
          if (instrRsp.valid) begin
            cmd.loadDlistLo <= isJump;
            cmd.loadScanLo <= !isJump;
            cmd.data <= instrRsp.data;
            cmd.instrReq <= 1'b1;
            state <= fetchHi;
          end
        end
        fetchHi: begin
          if (instrRsp.valid) begin
            cmd.data <= instrRsp.data;
            if (isJump) begin
              cmd.loadDlistHi <= 1'b1;
              if (instr[6]) begin
                nmi.vbi <= 1'b1;
                state <= waitVblank;
              end else begin
                cmd.instrReq <= 1'b1;
                state <= fetchInstr;
              end
            end else begin
              cmd.loadScanHi <= 1'b1;
              cmd.lineStart <= 1'b1;
              cmd.lineDouble <= heldOp == anticPkg::map4DoubleOp;
              state <= lineRun;
            end
          end
        end
        blankRun: begin
          if (lineDone) begin
            if (linesLeft == 3'd0) begin
              nmi.dli <= instr[7];
              cmd.instrReq <= 1'b1;
              state <= fetchInstr;
            end else begin
              linesLeft <= linesLeft - 3'd1;
              cmd.lineStart <= 1'b1;
            end
          end
        end
        lineRun: begin
          if (lineDone) begin
            nmi.dli <= instr[7];
            cmd.instrReq <= 1'b1;
            state <= fetchInstr;
          end
        end
        waitVblank: begin
          if (vblank) begin
            cmd.instrReq <= 1'b1;
            state <= fetchInstr;
          end
        end
        default: state <= idle;
      endcase
    end
  end

endmodule

// File: rtl/fetchPort.sv
// Memory request port with credit flow control, display-list pointer and scan counter
// Responses come back in order and are split by kind
`include "anticSettings.svh"

module fetchPort (
  input  logic Fphi0,
  input  logic rst,
  input  anticPkg::seqCmd cmd,
  input  logic screenWant,
  input  logic [`ANTIC_ADDR_W-1:0] startPtr,
  input  logic startLoad,
  output anticPkg::fetchReq req,
  input  anticPkg::fetchRsp rsp,
  output anticPkg::fetchRsp instrRsp,
  output anticPkg::fetchRsp screenRsp,
  output logic screenTaken
);

  localparam int CreditW = $clog2(`ANTIC_FETCH_CREDITS + 1);

  logic [CreditW-1:0] credits;
  logic [`ANTIC_ADDR_W-1:0] dlistPtr;
  logic [`ANTIC_ADDR_W-1:0] scanPtr;
  logic [7:0] jumpLo;
  logic instrPending;
  logic haveCredit;
  logic instrIssue;
  logic screenIssue;

  assign haveCredit = credits != '0;
  assign instrIssue = instrPending && haveCredit;
  // Screen reads only go out when no instruction read is waiting
  assign screenIssue = screenWant && !instrPending && haveCredit;
  assign screenTaken = screenIssue;

  always_ff @(posedge Fphi0 or posedge rst) begin
    if (rst) begin
      credits <= CreditW'(`ANTIC_FETCH_CREDITS);
      instrPending <= 1'b0;
      dlistPtr <= '0;
      scanPtr <= '0;
      req <= '0;
    end else begin
      credits <= credits - CreditW'(instrIssue || screenIssue) + CreditW'(rsp.valid);
      instrPending <= cmd.instrReq || (instrPending && !instrIssue);

      req.valid <= instrIssue || screenIssue;
      req.kind <= instrIssue ? anticPkg::instrFetch : anticPkg::screenFetch;
      req.addr <= instrIssue ? dlistPtr : scanPtr;

      // A jump target replaces the pointer only once both bytes are in
      if (startLoad) begin
        dlistPtr <= startPtr;
      end else if (cmd.loadDlistHi) begin
        dlistPtr <= {cmd.data, jumpLo};
      end else if (instrIssue) begin
        dlistPtr <= dlistPtr + 1'b1;
      end

      if (cmd.loadScanLo) begin
        scanPtr[7:0] <= cmd.data;
      end else if (cmd.loadScanHi) begin
        scanPtr[15:8] <= cmd.data;
      end else if (screenIssue) begin
        scanPtr <= scanPtr + 1'b1;
      end
    end
  end

  always_ff @(posedge Fphi0) begin
    if (cmd.loadDlistLo) begin
      jumpLo <= cmd.data;
    end
  end

  always_comb begin
    instrRsp = rsp;
    screenRsp = rsp;
    instrRsp.valid = rsp.valid && rsp.kind == anticPkg::instrFetch;
    screenRsp.valid = rsp.valid && rsp.kind == anticPkg::screenFetch;
  end

endmodule

// File: rtl/dmaControl.sv
// DMA control and display-list start pointer registers
// Writes arrive one per valid cycle on regIn
`include "anticSettings.svh"

module dmaControl (
  input  logic Fphi0,
  input  logic rst,
  input  anticPkg::regWrite regIn,
  output logic dlistEnable,
  output logic [6:0] playfieldBytes,
  output logic [`ANTIC_ADDR_W-1:0] startPtr,
  output logic startLoad
);

  // Only the enable bit and the width field of the control byte are kept
  logic [1:0] widthSel;
  logic [7:0] startLo;
  logic [7:0] startHi;

  always_ff @(posedge Fphi0 or posedge rst) begin
    if (rst) begin
      dlistEnable <= 1'b0;
      widthSel <= 2'd0;
      startLoad <= 1'b0;
    end else begin
      startLoad <= regIn.valid && regIn.sel == anticPkg::dlistHiReg;
      if (regIn.valid && regIn.sel == anticPkg::dmactlReg) begin
        dlistEnable <= regIn.data[5];
        widthSel <= regIn.data[1:0];
      end
    end
  end

  always_ff @(posedge Fphi0) begin
    if (regIn.valid && regIn.sel == anticPkg::dlistLoReg) begin
      startLo <= regIn.data;
    end
    if (regIn.valid && regIn.sel == anticPkg::dlistHiReg) begin
      startHi <= regIn.data;
    end
  end

  assign startPtr = {startHi, startLo};

  always_comb begin
    case (widthSel)
      2'd1: playfieldBytes = 7'(`ANTIC_BYTES_NARROW);
      2'd2: playfieldBytes = 7'(`ANTIC_BYTES_STANDARD);
      2'd3: playfieldBytes = 7'(`ANTIC_BYTES_WIDE);
      default: playfieldBytes = 7'd0;
    endcase
  end

endmodule

// File: rtl/anticPkg.sv
// Enums and packed structs shared by the display-list engine and its testbench
`include "anticSettings.svh"

package anticPkg;

  // Low nibble of a display-list instruction
  typedef enum logic [3:0] {
    blankOp = 4'd0,
    jumpOp = 4'd1,
    map4DoubleOp = 4'd13,
    map4Op = 4'd14
  } instrOp;

  // Colour codes sent to the colour chip
  typedef enum logic [2:0] {
    noTransmission = 3'd0,
    bgColor = 3'd1,
    playfield0 = 3'd2,
    playfield1 = 3'd3,
    playfield2 = 3'd4
  } anCode;

  typedef enum logic {
    instrFetch = 1'b0,
    screenFetch = 1'b1
  } fetchKind;

  typedef enum logic [1:0] {
    dmactlReg = 2'd0,
    dlistLoReg = 2'd1,
    dlistHiReg = 2'd2
  } regSel;

  typedef struct packed {
    logic valid;
    fetchKind kind;
    logic [`ANTIC_ADDR_W-1:0] addr;
  } fetchReq;

  typedef struct packed {
    logic valid;
    fetchKind kind;
    logic [7:0] data;
  } fetchRsp;

  typedef struct packed {
    logic valid;
    regSel sel;
    logic [7:0] data;
  } regWrite;

  typedef struct packed {
    logic dli;
    logic vbi;
  } nmiEvent;

  // Strobes from the sequencer, all single-cycle, with the byte they carry
  typedef struct packed {
    logic instrReq;
    logic loadDlistLo;
    logic loadDlistHi;
    logic loadScanLo;
    logic loadScanHi;
    logic lineStart;
    logic lineDouble;
    logic [7:0] data;
  } seqCmd;

endpackage

// File: rtl/anticSettings.svh
// Width, credit and line-length constants for the display-list engine
// Included by the package, the RTL modules and the testbench
`ifndef ANTIC_SETTINGS_SVH
`define ANTIC_SETTINGS_SVH

// Memory address width in bits
`define ANTIC_ADDR_W 16

// Reads that may be outstanding on the memory port at once
`define ANTIC_FETCH_CREDITS 2

// Colour codes in one blank scan line
`define ANTIC_LINE_PIXELS 320

// Screen bytes per map line for each playfield width
`define ANTIC_BYTES_NARROW 32
`define ANTIC_BYTES_STANDARD 40
`define ANTIC_BYTES_WIDE 48

`endif
